// File: bench/fpmul_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module fpmul_asserts (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       in_valid,
    input  wire logic       s1_valid,
    input  wire logic       s2_valid,
    input  wire logic       s3_valid,
    input  wire logic       out_valid,
    input  wire logic       norm_lead,
    input  wire logic [1:0] norm_forced,
    input  wire logic       zer,
    input  wire logic       udrf
);

    import fpmul_pipe_pkg::*;

    // Each stage strobe trails its predecessor by one cycle
    s1_follows: assert property (@(posedge clk) disable iff (rst)
        s1_valid == $past(in_valid))
        else $error("stage 1 valid does not follow in_valid");

    s2_follows: assert property (@(posedge clk) disable iff (rst)
        s2_valid == $past(s1_valid))
        else $error("stage 2 valid does not follow stage 1");

    s3_follows: assert property (@(posedge clk) disable iff (rst)
        s3_valid == $past(s2_valid))
        else $error("stage 3 valid does not follow stage 2");

    out_follows: assert property (@(posedge clk) disable iff (rst)
        out_valid == $past(s3_valid))
        else $error("out_valid does not follow stage 3");

    // Normal operands always leave a hidden bit after the shift
    lead_set: assert property (@(posedge clk) disable iff (rst)
        (s3_valid && norm_forced == FORCE_NONE) |-> norm_lead)
        else $error("normalized fraction lost its leading one");

    // Underflow flushes to zero
    udrf_zero: assert property (@(posedge clk) disable iff (rst)
        (out_valid && udrf) |-> zer)
        else $error("udrf raised without zer");

endmodule

bind fpmul_top fpmul_asserts u_asserts (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .s1_valid    (unpack_if.valid),
    .s2_valid    (mult_if.valid),
    .s3_valid    (norm_if.valid),
    .out_valid   (out_valid),
    .norm_lead   (norm_if.data.frac[26]),
    .norm_forced (norm_if.data.forced),
    .zer         (zer),
    .udrf        (udrf)
);

`default_nettype wire

// File: bench/fpmul_checker.sv
`timescale 1ns/100ps
`default_nettype none

module fpmul_checker (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        in_valid,
    input  wire logic        out_valid,
    input  wire logic [31:0] z,
    input  wire logic        zer,
    input  wire logic        inf,
    input  wire logic        nan,
    input  wire logic        ovrf,
    input  wire logic        udrf
);

    // Cycles from the accepting edge to the edge that sees out_valid
    localparam int LATENCY = 4;

    // Expected results in issue order
    logic [31:0] exp_z [$];
    logic [4:0]  exp_flags [$];
    string       exp_name [$];
    // Cycle numbers at which the DUT accepted an operation
    longint      accept_cycle [$];

    longint      cycle = 0;
    int          n_pass = 0;
    int          n_fail = 0;
    int          n_err = 0;

    // Called by the testbench on the edge that drives the operands
    task automatic push_expected(input logic [31:0] ez, input logic [4:0] ef, input string name);
        exp_z.push_back(ez);
        exp_flags.push_back(ef);
        exp_name.push_back(name);
    endtask

    function automatic int pending_count();
        return exp_z.size();
    endfunction

    function automatic int error_count();
        return n_fail + n_err;
    endfunction

    task automatic check_result();
        logic [31:0] ez;
        logic [4:0]  ef;
        logic [4:0]  af;
        string       name;
        longint      lat;
        // Flag order matches the test data column
        af = {zer, inf, nan, ovrf, udrf};
        if (exp_z.size() == 0) begin
            $display("DUT produced a result at cycle %0d with no expected entry pending", cycle);
            n_err++;
        end else begin
            ez   = exp_z.pop_front();
            ef   = exp_flags.pop_front();
            name = exp_name.pop_front();
            lat  = -1;
            if (accept_cycle.size() != 0) begin
                lat = cycle - accept_cycle.pop_front();
            end
            if (z !== ez || af !== ef) begin
                $display("[FAIL] %s expected z=%h flags=%b actual z=%h flags=%b",
                         name, ez, ef, z, af);
                n_fail++;
            end else if (lat != LATENCY) begin
                $display("[FAIL] %s expected latency %0d actual %0d", name, LATENCY, lat);
                n_fail++;
            end else begin
                $display("[PASS] %s z=%h flags=%b", name, z, af);
                n_pass++;
            end
        end
    endtask

    // Leftover entries mean the DUT dropped results
    task automatic report_summary();
        if (exp_z.size() != 0) begin
            $display("%0d expected results were never produced by the DUT", exp_z.size());
            n_err++;
        end
        $display("Tests: %0d  passed: %0d  failed: %0d  other errors: %0d",
                 n_pass + n_fail, n_pass, n_fail, n_err);
    endtask

    // Sample on the edge, DUT outputs settled in the previous cycle
    always @(posedge clk) begin
        if (!rst) begin
            if (in_valid) begin
                accept_cycle.push_back(cycle);
            end
            if (out_valid) begin
                check_result();
            end
        end
        cycle++;
    end

endmodule

`default_nettype wire

// File: bench/fpmul_testdata.txt
# x y mode expected_z expected_flags name, all hex except name
# mode 0 rne 1 rtz 2 rdn 3 rup 4 rmm, flags are zer inf nan ovrf udrf
40400000 40400000 0 41100000 00 exact_3x3
3FC00000 3FC00000 0 40100000 00 exact_1p5x1p5
40000000 3F000000 0 3F800000 00 exact_2xhalf
C0400000 40400000 0 C1100000 00 exact_neg_3x3
40400000 40400000 3 41100000 00 exact_rup
C0400000 40400000 2 C1100000 00 exact_rdn
3F800001 3FC00000 0 3FC00002 00 tie_odd_rne
3F800003 3FC00000 0 3FC00004 00 tie_even_rne
3F800003 3FC00000 4 3FC00005 00 tie_even_rmm
3F800003 3FC00000 1 3FC00004 00 tie_even_rtz
3F800001 3F800001 0 3F800002 00 inexact_pos_rne
3F800001 3F800001 1 3F800002 00 inexact_pos_rtz
3F800001 3F800001 2 3F800002 00 inexact_pos_rdn
3F800001 3F800001 3 3F800003 00 inexact_pos_rup
3F800001 3F800001 4 3F800002 00 inexact_pos_rmm
BF800001 3F800001 0 BF800002 00 inexact_neg_rne
BF800001 3F800001 1 BF800002 00 inexact_neg_rtz
BF800001 3F800001 2 BF800003 00 inexact_neg_rdn
BF800001 3F800001 3 BF800002 00 inexact_neg_rup
BF800001 3F800001 4 BF800002 00 inexact_neg_rmm
00000000 40400000 0 00000000 10 zero_pos
80000000 40400000 0 80000000 10 zero_neg
00000001 3F800000 0 00000000 10 subnorm_pos
00400000 BF800000 0 80000000 10 subnorm_neg
7F800000 40000000 0 7F800000 08 inf_pos
7F800000 C0000000 0 FF800000 08 inf_neg
7FC00001 3F800000 0 7FC00000 04 nan_in_x
3F800000 FF812345 0 7FC00000 04 nan_in_y
7F800000 00000000 0 7FC00000 04 inf_x_zero
00000003 FF800000 0 7FC00000 04 subnorm_x_inf
7F000000 40000000 0 7F800000 0A ovf_rne
7F000000 40000000 1 7F7FFFFF 0A ovf_rtz
7F000000 40000000 2 7F7FFFFF 0A ovf_rdn_pos
7F000000 40000000 3 7F800000 0A ovf_rup_pos
7F000000 40000000 4 7F800000 0A ovf_rmm
FF000000 40000000 2 FF800000 0A ovf_rdn_neg
FF000000 40000000 3 FF7FFFFF 0A ovf_rup_neg
20000000 1F800000 0 00000000 11 udf_pos
A0000000 1F800000 0 80000000 11 udf_neg

// File: bench/tb_fpmul.sv
`timescale 1ns/100ps
`default_nettype none

module tb_fpmul;

    import fp_format_pkg::*;

    localparam int          HALF_PERIOD  = 2;
    localparam int          RESET_CYCLES = 5;
    localparam int          MAX_GAP      = 2;
    localparam logic [31:0] SEED         = 32'ha41bdfb3;
    localparam string       DATA_FILE    = "bench/fpmul_testdata.txt";

    logic        clk;
    logic        rst;
    logic        in_valid;
    fp32_t       x;
    fp32_t       y;
    round_mode_e mode;
    logic        out_valid;
    fp32_t       z;
    logic        zer;
    logic        inf;
    logic        nan;
    logic        ovrf;
    logic        udrf;

    // Test vectors from the data file
    logic [31:0] t_x [$];
    logic [31:0] t_y [$];
    logic [2:0]  t_mode [$];
    logic [31:0] t_z [$];
    logic [4:0]  t_flags [$];
    string       t_name [$];
    bit          loaded = 1'b0;

    fpmul_top DUT (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .x         (x),
        .y         (y),
        .mode      (mode),
        .out_valid (out_valid),
        .z         (z),
        .zer       (zer),
        .inf       (inf),
        .nan       (nan),
        .ovrf      (ovrf),
        .udrf      (udrf)
    );

    fpmul_checker chk (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .out_valid (out_valid),
        .z         (z),
        .zer       (zer),
        .inf       (inf),
        .nan       (nan),
        .ovrf      (ovrf),
        .udrf      (udrf)
    );

    initial clk = 1'b0;
    always #HALF_PERIOD clk = ~clk;

    // Comment and blank lines fail the scan and are skipped
    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] vx;
        logic [31:0] vy;
        logic [2:0]  vm;
        logic [31:0] vz;
        logic [4:0]  vf;
        string       vname;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open test data file %s", DATA_FILE);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %s", vx, vy, vm, vz, vf, vname);
                    if (n == 6) begin
                        t_x.push_back(vx);
                        t_y.push_back(vy);
                        t_mode.push_back(vm);
                        t_z.push_back(vz);
                        t_flags.push_back(vf);
                        t_name.push_back(vname);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // One sweep over all vectors, idle gaps random or none
    task automatic run_pass(input bit back_to_back);
        int    gap;
        string prefix;
        prefix = back_to_back ? "b2b_" : "";
        for (int i = 0; i < t_x.size(); i++) begin
            gap = back_to_back ? 0 : int'($urandom % (MAX_GAP + 1));
            repeat (gap) begin
                @(posedge clk);
                in_valid <= 1'b0;
            end
            @(posedge clk);
            in_valid <= 1'b1;
            x        <= t_x[i];
            y        <= t_y[i];
            mode     <= round_mode_e'(t_mode[i]);
            chk.push_expected(t_z[i], t_flags[i], {prefix, t_name[i]});
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    initial begin : main
        int setup_errors;
        setup_errors = 0;
        rst      = 1'b1;
        in_valid = 1'b0;
        x        = '0;
        y        = '0;
        mode     = RM_RNE;
        void'($urandom(SEED));
        load_vectors();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        if (t_x.size() == 0) begin
            $display("No test vectors were read from %s", DATA_FILE);
            setup_errors = 1;
        end else begin
            run_pass(1'b0);
            // Second sweep issues every cycle to fill the pipeline
            run_pass(1'b1);
            while (chk.pending_count() != 0) begin
                @(posedge clk);
            end
            // Catch any stray out_valid after the last result
            repeat (8) @(posedge clk);
        end
        chk.report_summary();
        if (chk.error_count() == 0 && setup_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Eight cycles per issued operation plus margin for reset and drain
    initial begin : watchdog
        int limit;
        wait (loaded);
        limit = 2 * t_x.size() * 8 + 100;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the floating-point multiplier testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f sim.f --top-module tb_fpmul -Mdir obj_dir -o Vtb_fpmul

# A failing simulation must not stop the script before the search
out=$(./obj_dir/Vtb_fpmul) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
    exit 0
else
    exit 1
fi

// File: sim.f
source/fp_format_pkg.sv
source/fpmul_pipe_pkg.sv
source/fpmul_stage_if.sv
source/fpmul_unpack.sv
source/fpmul_mant_mult.sv
source/fpmul_normalize.sv
source/fpmul_round_pack.sv
source/fpmul_top.sv
bench/fpmul_checker.sv
bench/fpmul_asserts.sv
bench/tb_fpmul.sv

// File: source/fp_format_pkg.sv
`default_nettype none

package fp_format_pkg;

    // IEEE 754 single precision field widths
    localparam int EXP_W  = 8;
    localparam int FRAC_W = 23;
    // Significand width including the hidden bit
    localparam int SIG_W  = FRAC_W + 1;

    localparam int EXP_BIAS = 127;

    // Exponent field of inf and NaN
    localparam logic [EXP_W-1:0] EXP_ONES = '1;

    // One single-precision word split into its fields
    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exp;
        logic [FRAC_W-1:0] frac;
    } fp32_t;

    // Canonical quiet NaN for every NaN result
    localparam fp32_t QNAN = 32'h7FC00000;

    // Largest finite magnitude without the sign bit
    localparam logic [30:0] MAX_FINITE = 31'h7F7FFFFF;

    // Rounding mode encodings
    typedef enum logic [2:0] {
        RM_RNE = 3'b000,
        RM_RTZ = 3'b001,
        RM_RDN = 3'b010,
        RM_RUP = 3'b011,
        RM_RMM = 3'b100
    } round_mode_e;

    // Operand class, subnormals are folded into zero
    typedef struct packed {
        logic zero;
        logic inf;
        logic nan;
    } fp_class_t;

endpackage

`default_nettype wire

// File: source/fpmul_mant_mult.sv
`timescale 1ns/100ps
`default_nettype none

module fpmul_mant_mult (
    input  wire logic  clk,
    input  wire logic  rst,
    fpmul_stage_if.dst i,
    fpmul_stage_if.src o
);

    import fpmul_pipe_pkg::*;

    // Multiplier with two zero bits on top and the implicit b[-1] below
    logic [26:0]       b_ext;
    logic [PROD_W-1:0] pp [13];
    logic [PROD_W-1:0] acc;
    mult_out_t         nxt;

    // One radix-4 Booth digit applied to the multiplicand
    function automatic logic [47:0] booth_pp(input logic [2:0] trip, input logic [23:0] a);
        logic [47:0] a_ext;
        a_ext = {24'b0, a};
        case (trip)
            3'b001, 3'b010: booth_pp = a_ext;
            3'b011:         booth_pp = a_ext << 1;
            3'b100:         booth_pp = -(a_ext << 1);
            3'b101, 3'b110: booth_pp = -a_ext;
            // 000 and 111 give nothing
            default:        booth_pp = '0;
        endcase
    endfunction

    always_comb begin
        b_ext = {2'b00, i.data.sig_y, 1'b0};

        // Triplet k covers multiplier bits 2k+1, 2k and 2k-1
        for (int k = 0; k < 13; k++) begin
            pp[k] = booth_pp(b_ext[2*k +: 3], i.data.sig_x) << (2 * k);
        end

        // Two's complement sum modulo 2^48, the true product always fits
        acc = '0;
        for (int k = 0; k < 13; k++) begin
            acc = acc + pp[k];
        end

        nxt.sign   = i.data.sign;
        nxt.exp    = i.data.exp;
        nxt.prod   = acc;
        nxt.mode   = i.data.mode;
        nxt.forced = i.data.forced;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o.valid <= 1'b0;
        end else begin
            o.valid <= i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i.valid) begin
            o.data <= nxt;
        end
    end

endmodule

`default_nettype wire

// File: source/fpmul_normalize.sv
`timescale 1ns/100ps
`default_nettype none

module fpmul_normalize (
    input  wire logic  clk,
    input  wire logic  rst,
    fpmul_stage_if.dst i,
    fpmul_stage_if.src o
);

    import fpmul_pipe_pkg::*;

    logic              norm_n;
    logic [PROD_W-1:0] shifted;
    norm_out_t         nxt;

    always_comb begin
        // Product of two normal significands lies in [1, 4)
        norm_n  = i.data.prod[47];
        shifted = norm_n ? i.data.prod : {i.data.prod[46:0], 1'b0};

        nxt.sign = i.data.sign;
        // A product of 2 or more moves the point one place left
        nxt.exp  = i.data.exp + 10'(norm_n);

        // Hidden bit, fraction, guard and round, then sticky over the rest
        nxt.frac   = {shifted[47:22], |shifted[21:0]};
        nxt.norm_n = norm_n;
        nxt.mode   = i.data.mode;
        nxt.forced = i.data.forced;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o.valid <= 1'b0;
        end else begin
            o.valid <= i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i.valid) begin
            o.data <= nxt;
        end
    end

endmodule

`default_nettype wire

// File: source/fpmul_pipe_pkg.sv
`default_nettype none

package fpmul_pipe_pkg;

    import fp_format_pkg::*;

    // Signed biased exponent sum, wide enough for -127..384
    localparam int EXP_SUM_W = 10;
    localparam int PROD_W    = 2 * SIG_W;
    // Hidden bit, 23 fraction bits, guard, round and sticky
    localparam int NORM_W    = 27;

    // Result forced by the operand classes
    typedef enum logic [1:0] {
        FORCE_NONE,
        FORCE_ZERO,
        FORCE_INF,
        FORCE_NAN
    } force_e;

    typedef struct packed {
        logic zer;
        logic inf;
        logic nan;
        logic ovrf;
        logic udrf;
    } fpmul_flags_t;

    // Stage 1 to stage 2
    typedef struct packed {
        logic                        sign;
        logic signed [EXP_SUM_W-1:0] exp;
        logic [SIG_W-1:0]            sig_x;
        logic [SIG_W-1:0]            sig_y;
        round_mode_e                 mode;
        force_e                      forced;
    } unpack_out_t;

    // Stage 2 to stage 3
    typedef struct packed {
        logic                        sign;
        logic signed [EXP_SUM_W-1:0] exp;
        logic [PROD_W-1:0]           prod;
        round_mode_e                 mode;
        force_e                      forced;
    } mult_out_t;

    // Stage 3 to stage 4
    typedef struct packed {
        logic                        sign;
        logic signed [EXP_SUM_W-1:0] exp;
        logic [NORM_W-1:0]           frac;
        logic                        norm_n;
        round_mode_e                 mode;
        force_e                      forced;
    } norm_out_t;

    // Priority of special cases
    // NaN wins, then inf, then zero
    function automatic force_e resolve_force(input fp_class_t a, input fp_class_t b);
        if (a.nan || b.nan || (a.inf && b.zero) || (a.zero && b.inf)) begin
            return FORCE_NAN;
        end else if (a.inf || b.inf) begin
            return FORCE_INF;
        end else if (a.zero || b.zero) begin
            return FORCE_ZERO;
        end
        return FORCE_NONE;
    endfunction

endpackage

`default_nettype wire

// File: source/fpmul_round_pack.sv
`timescale 1ns/100ps
`default_nettype none

module fpmul_round_pack (
    input  wire logic                     clk,
    input  wire logic                     rst,
    fpmul_stage_if.dst                    i,
    output logic                          out_valid,
    output fp_format_pkg::fp32_t          z,
    output fpmul_pipe_pkg::fpmul_flags_t  flags
);

    import fp_format_pkg::*;
    import fpmul_pipe_pkg::*;

    logic [22:0]                 mant;
    logic                        guard;
    logic                        sticky;
    logic                        inexact;
    logic                        round_up;
    logic                        norm_r;
    logic [22:0]                 mant_r;
    logic signed [EXP_SUM_W-1:0] exp_r;
    logic                        ovf_to_inf;
    fp32_t                       z_nxt;
    fpmul_flags_t                flags_nxt;

    always_comb begin
        mant    = i.data.frac[25:3];
        guard   = i.data.frac[2];
        // Round bit folds into sticky
        sticky  = |i.data.frac[1:0];
        inexact = guard | sticky;

        case (i.data.mode)
            RM_RNE:  round_up = guard & (sticky | mant[0]);
            RM_RTZ:  round_up = 1'b0;
            // Directed modes only step when bits were dropped
            RM_RDN:  round_up = i.data.sign & inexact;
            RM_RUP:  round_up = ~i.data.sign & inexact;
            RM_RMM:  round_up = guard;
            default: round_up = 1'b0;
        endcase

        // Carry out means the significand reached 2.0 and the fraction wrapped to zero
        {norm_r, mant_r} = {1'b0, mant} + 24'(round_up);
        exp_r            = i.data.exp + 10'(norm_r);

        // Modes that round away from the result go to inf on overflow
        case (i.data.mode)
            RM_RNE:  ovf_to_inf = 1'b1;
            RM_RMM:  ovf_to_inf = 1'b1;
            RM_RDN:  ovf_to_inf = i.data.sign;
            RM_RUP:  ovf_to_inf = ~i.data.sign;
            default: ovf_to_inf = 1'b0;
        endcase

        flags_nxt = '0;
        z_nxt     = {i.data.sign, exp_r[7:0], mant_r};

        if (exp_r >= 10'sd255) begin
            flags_nxt.ovrf = 1'b1;
            flags_nxt.inf  = 1'b1;
            z_nxt = ovf_to_inf ? {i.data.sign, EXP_ONES, 23'b0} : {i.data.sign, MAX_FINITE};
        end else if (exp_r <= 10'sd0) begin
            // No subnormal outputs, flush to signed zero
            flags_nxt.udrf = 1'b1;
            flags_nxt.zer  = 1'b1;
            z_nxt = {i.data.sign, 31'b0};
        end

        // Special operands override whatever the datapath produced
        case (i.data.forced)
            FORCE_ZERO: begin
                flags_nxt     = '0;
                flags_nxt.zer = 1'b1;
                z_nxt         = {i.data.sign, 31'b0};
            end
            FORCE_INF: begin
                flags_nxt     = '0;
                flags_nxt.inf = 1'b1;
                z_nxt         = {i.data.sign, EXP_ONES, 23'b0};
            end
            FORCE_NAN: begin
                flags_nxt     = '0;
                flags_nxt.nan = 1'b1;
                z_nxt         = QNAN;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= i.valid;
        end
    end

    // Result and flags hold until the next valid item
    always_ff @(posedge clk) begin
        if (i.valid) begin
            z     <= z_nxt;
            flags <= flags_nxt;
        end
    end

endmodule

`default_nettype wire

// File: source/fpmul_stage_if.sv
`timescale 1ns/100ps
`default_nettype none

// Link between two adjacent pipeline stages
interface fpmul_stage_if #(
    parameter type payload_t = logic
);

    // One-cycle strobe per item, no back-pressure
    logic     valid;
    payload_t data;

    // Producer side
    modport src (output valid, output data);

    // Consumer side
    modport dst (input valid, input data);

endinterface

`default_nettype wire

// File: source/fpmul_top.sv
`timescale 1ns/100ps
`default_nettype none

module fpmul_top (
    input  wire  logic                       clk,
    input  wire  logic                       rst,
    input  wire  logic                       in_valid,
    input  wire  fp_format_pkg::fp32_t       x,
    input  wire  fp_format_pkg::fp32_t       y,
    input  wire  fp_format_pkg::round_mode_e mode,
    output logic                             out_valid,
    output fp_format_pkg::fp32_t             z,
    output logic                             zer,
    output logic                             inf,
    output logic                             nan,
    output logic                             ovrf,
    output logic                             udrf
);

    import fpmul_pipe_pkg::*;

    fpmul_flags_t flags;

    // Stage links, each with its own payload
    fpmul_stage_if #(.payload_t(unpack_out_t)) unpack_if ();
    fpmul_stage_if #(.payload_t(mult_out_t))   mult_if ();
    fpmul_stage_if #(.payload_t(norm_out_t))   norm_if ();

    // Stage 1 classify and add exponents
    fpmul_unpack u_unpack (
        .clk      (clk),
        .rst      (rst),
        .x        (x),
        .y        (y),
        .mode     (mode),
        .in_valid (in_valid),
        .o        (unpack_if.src)
    );

    // Stage 2 Booth product
    fpmul_mant_mult u_mant_mult (
        .clk (clk),
        .rst (rst),
        .i   (unpack_if.dst),
        .o   (mult_if.src)
    );

    // Stage 3 normalize
    fpmul_normalize u_normalize (
        .clk (clk),
        .rst (rst),
        .i   (mult_if.dst),
        .o   (norm_if.src)
    );

    // Stage 4 round and pack
    fpmul_round_pack u_round_pack (
        .clk       (clk),
        .rst       (rst),
        .i         (norm_if.dst),
        .out_valid (out_valid),
        .z         (z),
        .flags     (flags)
    );

    // Flag bits leave as plain ports
    assign zer  = flags.zer;
    assign inf  = flags.inf;
    assign nan  = flags.nan;
    assign ovrf = flags.ovrf;
    assign udrf = flags.udrf;

endmodule

`default_nettype wire

// File: source/fpmul_unpack.sv
`timescale 1ns/100ps
`default_nettype none

module fpmul_unpack (
    input  wire  logic                       clk,
    input  wire  logic                       rst,
    input  wire  fp_format_pkg::fp32_t       x,
    input  wire  fp_format_pkg::fp32_t       y,
    input  wire  fp_format_pkg::round_mode_e mode,
    input  wire  logic                       in_valid,
    fpmul_stage_if.src                       o
);

    import fp_format_pkg::*;
    import fpmul_pipe_pkg::*;

    fp_class_t   cls_x;
    fp_class_t   cls_y;
    unpack_out_t nxt;

    always_comb begin
        // Exponent 0 covers both zero and subnormal
        cls_x.zero = (x.exp == '0);
        cls_x.inf  = (x.exp == EXP_ONES) && (x.frac == '0);
        cls_x.nan  = (x.exp == EXP_ONES) && (x.frac != '0);

        cls_y.zero = (y.exp == '0);
        cls_y.inf  = (y.exp == EXP_ONES) && (y.frac == '0);
        cls_y.nan  = (y.exp == EXP_ONES) && (y.frac != '0);

        nxt.sign = x.sign ^ y.sign;

        // Biased sum minus one bias keeps the result biased
        nxt.exp = 10'(x.exp) + 10'(y.exp) - 10'(EXP_BIAS);

        // Hidden bit is clear for zero and subnormal inputs
        nxt.sig_x = {|x.exp, x.frac};
        nxt.sig_y = {|y.exp, y.frac};

        nxt.mode   = mode;
        nxt.forced = resolve_force(cls_x, cls_y);
    end

    // Valid strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            o.valid <= 1'b0;
        end else begin
            o.valid <= in_valid;
        end
    end

    // Payload only loads on an accepted operation
    always_ff @(posedge clk) begin
        if (in_valid) begin
            o.data <= nxt;
        end
    end

endmodule

`default_nettype wire
